// ==== files.f ====
+incdir+common
common/mul_data_pkg.sv
common/mul_ctrl_pkg.sv
design/cla_adder.sv
radix4_mul/radix4_digit_decode.sv
radix4_mul/radix4_partial_array.sv
radix4_mul/mul_sequencer.sv
radix4_mul/mul_result.sv
radix4_mul/radix4_multiplier.sv
test/clk_gen.sv
test/multiplier_chk.sv
test/tb_multiplier.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_multiplier -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_multiplier +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

// ==== test/tb_multiplier.sv ====
// Testbench for the radix-4 fixed-point multiplier with reference model and strobe checks
`include "mul_settings.svh"

module tb_multiplier;

    timeunit 1ns;
    timeprecision 1ps;

    import mul_data_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_RANDOM = 200;
    // Random pairs plus the directed, timing, busy-trigger and back-to-back products
    localparam int NUM_PRODUCTS = NUM_RANDOM + 10;
    localparam int CYCLES_PER_PRODUCT = 20;
    localparam int DONE_TIMEOUT = 20;

    logic  ctl_clk;
    logic  reset;
    word_t a;
    word_t b;
    logic  trigger;
    word_t y;
    logic  ready;
    logic  done;

    word_t expected[$];
    int    results;
    int    errors;
    int    compare_errors;
    int    tests;

    clk_gen #(.PERIOD(CLK_PERIOD)) u_clk (
        .ctl_clk (ctl_clk),
        .reset   (reset)
    );

    radix4_multiplier u_dut (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .a       (a),
        .b       (b),
        .trigger (trigger),
        .y       (y),
        .ready   (ready),
        .done    (done)
    );

    bind radix4_multiplier multiplier_chk u_chk (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .trigger (trigger),
        .ready   (ready),
        .done    (done)
    );

    // Full-width product reduced to the fixed-point slice
    function automatic word_t ref_product(input word_t x, input word_t z);
        product_t full;
        full = product_t'(x) * product_t'(z);
        return full[`MUL_FRAC_BITS +: `MUL_WIDTH];
    endfunction

    function automatic int error_total();
        return errors + compare_errors + u_dut.u_chk.failures;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            compare_errors++;
        end
    endtask

    task automatic check_strobe(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int mark);
        tests++;
        if (error_total() == mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_total() - mark);
        end
    endtask

    task automatic wait_result(input int target);
        int cycles;
        cycles = 0;
        while (results < target && cycles < DONE_TIMEOUT) begin
            @(posedge ctl_clk);
            cycles++;
        end
        if (results < target) begin
            $display("No done pulse within %0d cycles of the trigger", DONE_TIMEOUT);
            errors++;
        end
    endtask

    // Returns on the capturing edge with trigger released
    task automatic launch(input word_t x, input word_t z);
        @(negedge ctl_clk);
        while (!ready) begin
            @(negedge ctl_clk);
        end
        @(posedge ctl_clk);
        a       <= x;
        b       <= z;
        trigger <= 1'b1;
        @(posedge ctl_clk);
        trigger <= 1'b0;
    endtask

    task automatic run_product(input word_t x, input word_t z);
        int target;
        target = results + 1;
        launch(x, z);
        wait_result(target);
    endtask

    task automatic timed_product(input word_t x, input word_t z);
        launch(x, z);
        for (int i = 0; i < 5; i++) begin
            @(negedge ctl_clk);
            check_strobe("ready", ready, 1'b0);
            check_strobe("done", done, 1'b0);
            @(posedge ctl_clk);
        end
        @(negedge ctl_clk);
        check_strobe("done", done, 1'b1);
        check_strobe("ready", ready, 1'b1);
        @(negedge ctl_clk);
        check_strobe("done", done, 1'b0);
    endtask

    task automatic busy_trigger(input word_t x1, input word_t z1,
                                input word_t x2, input word_t z2);
        int target;
        target = results + 1;
        launch(x1, z1);
        repeat (2) @(posedge ctl_clk);
        a       <= x2;
        b       <= z2;
        trigger <= 1'b1;
        @(posedge ctl_clk);
        trigger <= 1'b0;
        wait_result(target);
        repeat (8) @(posedge ctl_clk);
        if (results != target) begin
            $display("A trigger while busy started an extra product");
            errors++;
        end
    endtask

    // Trigger held through the first product starts the second in its done cycle
    task automatic back_to_back(input word_t x1, input word_t z1,
                                input word_t x2, input word_t z2);
        int target;
        target = results + 2;
        launch(x1, z1);
        a       <= x2;
        b       <= z2;
        trigger <= 1'b1;
        repeat (6) @(posedge ctl_clk);
        trigger <= 1'b0;
        @(negedge ctl_clk);
        check_strobe("ready", ready, 1'b0);
        wait_result(target);
    endtask

    // Expected values are queued at each capture and checked on each done
    always @(negedge ctl_clk) begin
        if (!reset) begin
            check_word("y", y, '0);
        end else begin
            if (trigger && ready) begin
                expected.push_back(ref_product(a, b));
            end
            if (done) begin
                if (expected.size() == 0) begin
                    $display("done pulsed with no product in flight");
                    compare_errors++;
                end else begin
                    check_word("y", y, expected.pop_front());
                end
                results++;
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (NUM_PRODUCTS * CYCLES_PER_PRODUCT + 100));
        $display("Watchdog expired before the tests finished");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int mark;
        void'($urandom(60));
        a       <= '0;
        b       <= '0;
        trigger <= 1'b0;

        mark = error_total();
        repeat (2) @(negedge ctl_clk);
        check_strobe("ready", ready, 1'b0);
        check_strobe("done", done, 1'b0);
        while (!reset) begin
            @(negedge ctl_clk);
        end
        @(negedge ctl_clk);
        check_strobe("ready", ready, 1'b1);
        check_strobe("done", done, 1'b0);
        check_word("y", y, '0);
        end_test("reset", mark);

        mark = error_total();
        run_product('0, 32'h1234_5678);
        run_product(32'h8765_4321, '0);
        run_product(word_t'(1) << `MUL_FRAC_BITS, 32'hABCD_EF01);
        run_product('1, 32'h0000_0001);
        // Every radix-4 digit is 3
        run_product('1, '1);
        end_test("directed", mark);

        mark = error_total();
        for (int i = 0; i < NUM_RANDOM; i++) begin
            run_product(word_t'($urandom()), word_t'($urandom()));
        end
        end_test("random", mark);

        mark = error_total();
        timed_product(32'h0001_2345, 32'h00C0_FFEE);
        end_test("strobe timing", mark);

        mark = error_total();
        busy_trigger(32'h0000_3A00, 32'h0001_0400, 32'hDEAD_BEEF, 32'hCAFE_F00D);
        end_test("busy trigger", mark);

        mark = error_total();
        back_to_back(32'h0F0F_0F0F, 32'h3333_3333, 32'hFFFF_0000, 32'h0000_FFFF);
        end_test("back to back", mark);

        $display("%0d tests, %0d products, %0d errors", tests, results, error_total());
        if (error_total() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== test/multiplier_chk.sv ====
// Strobe checker for the multiplier ready and done timing
module multiplier_chk (
    input logic ctl_clk,
    input logic reset,
    input logic trigger,
    input logic ready,
    input logic done
);

    timeunit 1ns;
    timeprecision 1ps;

    logic start;
    // Count of failed assertions
    int   failures = 0;

    assign start = trigger && ready;

    a_done_pulse: assert property (@(posedge ctl_clk) disable iff (!reset)
        done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            failures++;
        end

    a_busy_after_capture: assert property (@(posedge ctl_clk) disable iff (!reset)
        start |=> !ready)
        else begin
            $error("ready still high in the cycle after a capture");
            failures++;
        end

    // Done rises on the fifth edge after the capturing edge
    a_done_latency: assert property (@(posedge ctl_clk) disable iff (!reset)
        $past(start, 6) |-> done)
        else begin
            $error("done missing five cycles after a capture");
            failures++;
        end

    a_reset_strobes: assert property (@(posedge ctl_clk)
        !reset |=> !done && !ready)
        else begin
            $error("ready or done high during reset");
            failures++;
        end

endmodule

// ==== test/clk_gen.sv ====
// Testbench clock and reset source, 10 ns clock and active-low reset for three cycles
module clk_gen #(
    parameter int PERIOD = 10
) (
    output logic ctl_clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        ctl_clk = 1'b0;
        forever #(PERIOD / 2) ctl_clk = ~ctl_clk;
    end

    initial begin
        reset <= 1'b0;
        repeat (3) @(posedge ctl_clk);
        reset <= 1'b1;
    end

endmodule

// ==== radix4_mul/radix4_multiplier.sv ====
// Radix-4 hybrid fixed-point multiplier top level
module radix4_multiplier (
    input  logic                ctl_clk,
    input  logic                reset,
    input  mul_data_pkg::word_t a,
    input  mul_data_pkg::word_t b,
    input  logic                trigger,
    output mul_data_pkg::word_t y,
    output logic                ready,
    output logic                done
);

    import mul_data_pkg::*;

    word_t     multiplicand;
    chunk_u    chunk;
    word_t     acc_high;
    multiple_t multiple_0;
    multiple_t multiple_1;
    multiple_t multiple_2;
    multiple_t multiple_3;
    partial_t  step_sum;
    product_t  product;
    logic      finish;

    mul_sequencer u_sequencer (
        .ctl_clk      (ctl_clk),
        .reset        (reset),
        .trigger      (trigger),
        .a            (a),
        .b            (b),
        .step_sum     (step_sum),
        .multiplicand (multiplicand),
        .chunk        (chunk),
        .acc_high     (acc_high),
        .product      (product),
        .finish       (finish),
        .ready        (ready)
    );

    radix4_digit_decode u_decode (
        .multiplicand (multiplicand),
        .chunk        (chunk),
        .multiple_0   (multiple_0),
        .multiple_1   (multiple_1),
        .multiple_2   (multiple_2),
        .multiple_3   (multiple_3)
    );

    radix4_partial_array u_array (
        .multiple_0 (multiple_0),
        .multiple_1 (multiple_1),
        .multiple_2 (multiple_2),
        .multiple_3 (multiple_3),
        .acc_high   (acc_high),
        .step_sum   (step_sum)
    );

    mul_result u_result (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .finish  (finish),
        .product (product),
        .y       (y),
        .done    (done)
    );

endmodule

// ==== radix4_mul/mul_result.sv ====
// Result register holding the fixed-point product slice and the done pulse
`include "mul_settings.svh"

module mul_result (
    input  logic                   ctl_clk,
    input  logic                   reset,
    input  logic                   finish,
    input  mul_data_pkg::product_t product,
    output mul_data_pkg::word_t    y,
    output logic                   done
);

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            y    <= '0;
            done <= 1'b0;
        end else begin
            // finish lasts one cycle, so done does too
            done <= finish;
            if (finish) begin
                y <= product[`MUL_FRAC_BITS +: `MUL_WIDTH];
            end
        end
    end

endmodule

// ==== radix4_mul/mul_sequencer.sv ====
// Multiplier sequencer with FSM, step counter, operand and product registers
`include "mul_settings.svh"

module mul_sequencer (
    input  logic                   ctl_clk,
    input  logic                   reset,
    input  logic                   trigger,
    input  mul_data_pkg::word_t    a,
    input  mul_data_pkg::word_t    b,
    input  mul_data_pkg::partial_t step_sum,
    output mul_data_pkg::word_t    multiplicand,
    output mul_data_pkg::chunk_u   chunk,
    output mul_data_pkg::word_t    acc_high,
    output mul_data_pkg::product_t product,
    output logic                   finish,
    output logic                   ready
);

    import mul_data_pkg::*;
    import mul_ctrl_pkg::*;

    localparam int CHUNK_BITS = 2 * `MUL_DIGITS_PER_STEP;

    mul_state_e  state;
    mul_state_e  state_next;
    step_count_t step_count;
    word_t       multiplier;
    logic        start;
    logic        step;

    assign start      = trigger && ready;
    assign finish     = (state == ST_CALC) && (step_count == step_count_t'(MUL_STEPS));
    assign step       = (state == ST_CALC) && !finish;
    assign chunk.bits = multiplier[CHUNK_BITS-1:0];
    assign acc_high   = product[2*`MUL_WIDTH-1:`MUL_WIDTH];

    always_comb begin
        state_next = state;
        case (state)
            ST_CALC: begin
                if (finish) begin
                    state_next = ST_DONE;
                end
            end
            default: begin
                if (start) begin
                    state_next = ST_CALC;
                end else begin
                    state_next = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            state      <= ST_IDLE;
            ready      <= 1'b0;
            step_count <= '0;
        end else begin
            state <= state_next;
            ready <= (state_next != ST_CALC);
            if (start) begin
                step_count <= '0;
            end else if (step) begin
                step_count <= step_count + step_count_t'(1);
            end
        end
    end

    // Step sum lands on top, lower product bits shift down one chunk
    always_ff @(posedge ctl_clk) begin
        if (start) begin
            multiplicand <= a;
            multiplier   <= b;
            product      <= '0;
        end else if (step) begin
            multiplier <= multiplier >> CHUNK_BITS;
            product    <= {step_sum, product[`MUL_WIDTH-1:CHUNK_BITS]};
        end
    end

endmodule

// ==== radix4_mul/radix4_partial_array.sv ====
// Four-row adder array summing digit multiples and adding the accumulator
module radix4_partial_array (
    input  mul_data_pkg::multiple_t multiple_0,
    input  mul_data_pkg::multiple_t multiple_1,
    input  mul_data_pkg::multiple_t multiple_2,
    input  mul_data_pkg::multiple_t multiple_3,
    input  mul_data_pkg::word_t     acc_high,
    output mul_data_pkg::partial_t  step_sum
);

    import mul_data_pkg::*;

    localparam int M = $bits(multiple_t);
    localparam int P = $bits(partial_t);

    logic [M:0] row_0;
    logic [M:0] row_1;
    logic [M:0] row_2;
    logic [M:0] row_3;
    partial_t   chunk_product;
    logic [P:0] acc_sum;

    assign row_0 = {1'b0, multiple_0};

    // Each row adds the next digit multiple two bits higher
    cla_adder #(.WIDTH(M)) u_row_1 (
        .a   (multiple_1),
        .b   ({1'b0, row_0[M:2]}),
        .sum (row_1)
    );

    cla_adder #(.WIDTH(M)) u_row_2 (
        .a   (multiple_2),
        .b   ({1'b0, row_1[M:2]}),
        .sum (row_2)
    );

    cla_adder #(.WIDTH(M)) u_row_3 (
        .a   (multiple_3),
        .b   ({1'b0, row_2[M:2]}),
        .sum (row_3)
    );

    // Multiplicand times an 8-bit chunk fits in partial_t, top row bit stays zero
    assign chunk_product = {row_3[M-1:2], row_3[1:0], row_2[1:0], row_1[1:0], row_0[1:0]};

    cla_adder #(.WIDTH(P)) u_accumulate (
        .a   (chunk_product),
        .b   (partial_t'(acc_high)),
        .sum (acc_sum)
    );

    assign step_sum = acc_sum[P-1:0];

endmodule

// ==== radix4_mul/radix4_digit_decode.sv ====
// Radix-4 digit decoder selecting zero, x1, x2 or x3 of the multiplicand per digit
module radix4_digit_decode (
    input  mul_data_pkg::word_t     multiplicand,
    input  mul_data_pkg::chunk_u    chunk,
    output mul_data_pkg::multiple_t multiple_0,
    output mul_data_pkg::multiple_t multiple_1,
    output mul_data_pkg::multiple_t multiple_2,
    output mul_data_pkg::multiple_t multiple_3
);

    import mul_data_pkg::*;

    localparam int W = $bits(word_t);

    logic [W:0] times_2;
    multiple_t  times_3;
    multiple_t  selected [4];

    assign times_2 = {multiplicand, 1'b0};

    // x3 is the only multiple that needs an adder
    cla_adder #(
        .WIDTH (W + 1)
    ) u_times_3 (
        .a   ({1'b0, multiplicand}),
        .b   (times_2),
        .sum (times_3)
    );

    always_comb begin
        for (int i = 0; i < $size(selected); i++) begin
            case (chunk.digits[i])
                2'd0:    selected[i] = '0;
                2'd1:    selected[i] = multiple_t'(multiplicand);
                2'd2:    selected[i] = multiple_t'(times_2);
                default: selected[i] = times_3;
            endcase
        end
    end

    assign multiple_0 = selected[0];
    assign multiple_1 = selected[1];
    assign multiple_2 = selected[2];
    assign multiple_3 = selected[3];

endmodule

// ==== design/cla_adder.sv ====
// Carry-lookahead adder of 4-bit lookahead groups with a ripple carry tail
module cla_adder #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH:0]   sum
);

    localparam int GROUPS = WIDTH / 4;

    logic [WIDTH-1:0] p;
    logic [WIDTH-1:0] g;
    logic [WIDTH:0]   c;

    assign p    = a ^ b;
    assign g    = a & b;
    assign c[0] = 1'b0;

    // Group carries come from the group carry-in only
    for (genvar grp = 0; grp < GROUPS; grp++) begin : gen_group
        localparam int BASE = grp * 4;

        assign c[BASE+1] = g[BASE]
                         | (p[BASE] & c[BASE]);
        assign c[BASE+2] = g[BASE+1]
                         | (p[BASE+1] & g[BASE])
                         | (p[BASE+1] & p[BASE] & c[BASE]);
        assign c[BASE+3] = g[BASE+2]
                         | (p[BASE+2] & g[BASE+1])
                         | (p[BASE+2] & p[BASE+1] & g[BASE])
                         | (p[BASE+2] & p[BASE+1] & p[BASE] & c[BASE]);
        assign c[BASE+4] = g[BASE+3]
                         | (p[BASE+3] & g[BASE+2])
                         | (p[BASE+3] & p[BASE+2] & g[BASE+1])
                         | (p[BASE+3] & p[BASE+2] & p[BASE+1] & g[BASE])
                         | (p[BASE+3] & p[BASE+2] & p[BASE+1] & p[BASE] & c[BASE]);
    end

    // Full-adder cells for bits past the last whole group
    for (genvar i = GROUPS * 4; i < WIDTH; i++) begin : gen_tail
        assign c[i+1] = g[i] | (p[i] & c[i]);
    end

    assign sum = {c[WIDTH], p ^ c[WIDTH-1:0]};

endmodule

// ==== common/mul_ctrl_pkg.sv ====
// Control types for the multiplier sequencer state and step count
`include "mul_settings.svh"

package mul_ctrl_pkg;

    localparam int MUL_STEPS = `MUL_WIDTH / (2 * `MUL_DIGITS_PER_STEP);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CALC,
        ST_DONE
    } mul_state_e;

    // Counts the steps and one extra for the finish cycle
    typedef logic [$clog2(MUL_STEPS + 1)-1:0] step_count_t;

endpackage

// ==== common/mul_data_pkg.sv ====
// Datapath types for the radix-4 multiplier operands, multiples and products
`include "mul_settings.svh"

package mul_data_pkg;

    typedef logic [`MUL_WIDTH-1:0] word_t;

    typedef logic [2*`MUL_WIDTH-1:0] product_t;

    // Wide enough for three times the multiplicand
    typedef logic [`MUL_WIDTH+1:0] multiple_t;

    // Multiplicand times one chunk plus the accumulator
    typedef logic [`MUL_WIDTH+2*`MUL_DIGITS_PER_STEP-1:0] partial_t;

    typedef logic [1:0] digit_t;

    // Multiplier bits of one step, shifted as a word and decoded as digits
    typedef union packed {
        logic [2*`MUL_DIGITS_PER_STEP-1:0] bits;
        digit_t [`MUL_DIGITS_PER_STEP-1:0] digits;
    } chunk_u;

endpackage

// ==== common/mul_settings.svh ====
// Multiplier settings for operand width, fixed-point fraction and step size
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// Operand and result width
`define MUL_WIDTH 32

// Fraction bits of the fixed-point format
`define MUL_FRAC_BITS 8

// Radix-4 digits consumed per step, two multiplier bits each
`define MUL_DIGITS_PER_STEP 4

`endif
